// ==== common/r5p_pkg.sv ====
package r5p_pkg;

  ////////////////////////////////////////////////////////////
  // widths and constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned XW  = 32;           // register width
  localparam int unsigned IAW = 32;           // program address width
  localparam int unsigned DAW = 32;           // data address width
  localparam int unsigned DSW = 4;            // data byte select width
  localparam int unsigned DWW = $clog2(DSW);  // byte offset bits inside a word
  localparam int unsigned GAW = 5;            // gpr index width

  localparam logic [IAW-1:0] PC0 = '0;  // reset vector

  ////////////////////////////////////////////////////////////
  // enumerations
  ////////////////////////////////////////////////////////////

  // rv32i major opcodes, only the ones this core runs
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opc_t;

  typedef enum logic [1:0] {FETCH, EXEC, MEM, WB} ctl_state_t;

  // encoded as {funct7[5], funct3}, so decode is a plain cast
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SUB  = 4'b1000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_SRA  = 4'b1101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111
  } ao_t;

  // branch funct3 values, 3'b010 is free for none
  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_NONE = 3'b010,
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } br_t;

  typedef enum logic [1:0] {PC_PCI, PC_BRN, PC_JAL, PC_JALR} pc_t;
  typedef enum logic {A1_RS1, A1_PC} a1_t;
  typedef enum logic {A2_RS2, A2_IMM} a2_t;
  typedef enum logic [2:0] {WB_NONE, WB_ALU, WB_MEM, WB_PCI, WB_IMM} wb_t;
  typedef enum logic [1:0] {SZ_B = 2'b00, SZ_H = 2'b01, SZ_W = 2'b10} sz_t;  // = funct3[1:0]

  ////////////////////////////////////////////////////////////
  // decoded control
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic en;  // memory access
    logic we;  // store
    sz_t  sz;
    logic sg;  // sign extend load
  } ls_ctl_t;

  typedef struct packed {
    logic [GAW-1:0] rs1;
    logic [GAW-1:0] rs2;
    logic [GAW-1:0] rd;
    logic           we;  // instruction writes rd
  } gpr_ctl_t;

  typedef struct packed {
    ao_t           ao;
    br_t           br;
    pc_t           pc;
    a1_t           a1;
    a2_t           a2;
    wb_t           wb;
    ls_ctl_t       ls;
    gpr_ctl_t      gpr;
    logic [XW-1:0] imm;
  } ctl_t;

  // immediate, format picked from the opcode
  function automatic logic [XW-1:0] imm32(input logic [XW-1:0] op);
    logic [XW-1:0] imm;
    case (opc_t'(op[6:0]))
      OPC_OP_IMM, OPC_LOAD, OPC_JALR:
        imm = {{20{op[31]}}, op[31:20]};                                 // I
      OPC_STORE:
        imm = {{20{op[31]}}, op[31:25], op[11:7]};                       // S
      OPC_BRANCH:
        imm = {{19{op[31]}}, op[31], op[7], op[30:25], op[11:8], 1'b0};  // B
      OPC_LUI, OPC_AUIPC:
        imm = {op[31:12], 12'h000};                                      // U
      OPC_JAL:
        imm = {{11{op[31]}}, op[31], op[19:12], op[20], op[30:21], 1'b0};
      default:
        imm = '0;
    endcase
    return imm;
  endfunction

  function automatic ctl_t dec(input logic [XW-1:0] op);
    ctl_t       c;
    logic [2:0] f3;
    f3 = op[14:12];
    // defaults give a nop
    c.ao  = AO_ADD;
    c.br  = BR_NONE;
    c.pc  = PC_PCI;
    c.a1  = A1_RS1;
    c.a2  = A2_RS2;
    c.wb  = WB_NONE;
    c.ls.en = 1'b0;
    c.ls.we = 1'b0;
    c.ls.sz = sz_t'(f3[1:0]);
    c.ls.sg = ~f3[2];  // lbu/lhu have funct3[2] set
    c.gpr.rs1 = op[19:15];
    c.gpr.rs2 = op[24:20];
    c.gpr.rd  = op[11:7];
    c.gpr.we  = 1'b0;
    c.imm = imm32(op);
    case (opc_t'(op[6:0]))
      OPC_LUI: begin
        c.wb = WB_IMM;
        c.gpr.we = 1'b1;
      end
      OPC_AUIPC: begin
        c.a1 = A1_PC;
        c.a2 = A2_IMM;
        c.wb = WB_ALU;
        c.gpr.we = 1'b1;
      end
      OPC_JAL: begin
        c.pc = PC_JAL;  // target = pc + imm out of the alu sum
        c.a1 = A1_PC;
        c.a2 = A2_IMM;
        c.wb = WB_PCI;
        c.gpr.we = 1'b1;
      end
      OPC_JALR: begin
        c.pc = PC_JALR;
        c.a2 = A2_IMM;
        c.wb = WB_PCI;
        c.gpr.we = 1'b1;
      end
      OPC_BRANCH: begin
        c.pc = PC_BRN;
        c.br = br_t'(f3);
      end
      OPC_LOAD: begin
        c.ls.en = 1'b1;
        c.a2 = A2_IMM;
        c.wb = WB_MEM;
        c.gpr.we = 1'b1;
      end
      OPC_STORE: begin
        c.ls.en = 1'b1;
        c.ls.we = 1'b1;
        c.a2 = A2_IMM;
      end
      OPC_OP_IMM: begin
        c.ao = ao_t'({(f3 == 3'b101) & op[30], f3});  // only srai uses bit 30
        c.a2 = A2_IMM;
        c.wb = WB_ALU;
        c.gpr.we = 1'b1;
      end
      OPC_OP: begin
        c.ao = ao_t'({op[30], f3});
        c.wb = WB_ALU;
        c.gpr.we = 1'b1;
      end
      default: ;  // unsupported, runs as nop
    endcase
    return c;
  endfunction

endpackage

// ==== hw/r5p_alu.sv ====
`timescale 1ns/1ns

module r5p_alu (
  input  r5p_pkg::ao_t             ao,
  input  logic [r5p_pkg::XW-1:0]   rs1,
  input  logic [r5p_pkg::XW-1:0]   rs2,
  output logic [r5p_pkg::XW-1:0]   rd,
  output logic [r5p_pkg::XW-1:0]   sum
);

  import r5p_pkg::*;

  logic [$clog2(XW)-1:0] sh;  // shift amount

  assign sh  = rs2[$clog2(XW)-1:0];
  assign sum = rs1 + rs2;  // also used for addresses and jalr

  always_comb begin
    case (ao)
      AO_ADD:  rd = sum;
      AO_SUB:  rd = rs1 - rs2;
      AO_SLL:  rd = rs1 << sh;
      AO_SLT:  rd = XW'($signed(rs1) < $signed(rs2));
      AO_SLTU: rd = XW'(rs1 < rs2);
      AO_XOR:  rd = rs1 ^ rs2;
      AO_SRL:  rd = rs1 >> sh;
      AO_SRA:  rd = $unsigned($signed(rs1) >>> sh);  // sign bits shifted in
      AO_OR:   rd = rs1 | rs2;
      AO_AND:  rd = rs1 & rs2;
      default: rd = sum;
    endcase
  end

endmodule

// ==== hw/r5p_br.sv ====
`timescale 1ns/1ns

module r5p_br (
  input  r5p_pkg::br_t             br,
  input  logic [r5p_pkg::XW-1:0]   rs1,
  input  logic [r5p_pkg::XW-1:0]   rs2,
  output logic                     tkn
);

  import r5p_pkg::*;

  logic eq;
  logic lts;  // signed less than
  logic ltu;  // unsigned less than

  assign eq  = (rs1 == rs2);
  assign lts = ($signed(rs1) < $signed(rs2));
  assign ltu = (rs1 < rs2);

  always_comb begin
    case (br)
      BR_EQ:   tkn = eq;
      BR_NE:   tkn = !eq;
      BR_LT:   tkn = lts;
      BR_GE:   tkn = !lts;
      BR_LTU:  tkn = ltu;
      BR_GEU:  tkn = !ltu;
      default: tkn = 1'b0;  // not a branch
    endcase
  end

endmodule

// ==== hw/r5p_core.sv ====
`timescale 1ns/1ns

module r5p_core (
  input  logic                         clk,
  input  logic                         rst,
  // program bus
  output logic                         if_req,
  output logic [r5p_pkg::IAW-1:0]      if_adr,
  input  logic [r5p_pkg::XW-1:0]       if_rdt,
  input  logic                         if_ack,
  // data bus
  output logic                         ls_req,
  output logic                         ls_wen,
  output logic [r5p_pkg::DAW-1:0]      ls_adr,
  output logic [r5p_pkg::DSW-1:0]      ls_sel,
  output logic [8*r5p_pkg::DSW-1:0]    ls_wdt,
  input  logic [8*r5p_pkg::DSW-1:0]    ls_rdt,
  input  logic                         ls_ack
);

  import r5p_pkg::*;

  logic [XW-1:0]  ir;       // instruction register
  ctl_t           ctl;      // decoded ir
  logic           ir_ld;
  logic           pc_upd;
  logic           gpr_we;
  logic [IAW-1:0] pc;
  logic [IAW-1:0] pci;      // pc + 4, also link value
  logic           tkn;
  logic [XW-1:0]  gpr_rs1;
  logic [XW-1:0]  gpr_rs2;
  logic [XW-1:0]  gpr_rd;
  logic [XW-1:0]  alu_rs1;
  logic [XW-1:0]  alu_rs2;
  logic [XW-1:0]  alu_rd;
  logic [XW-1:0]  alu_sum;
  logic [XW-1:0]  lsu_rdt;
  logic           ls_cap;   // load data capture

  ////////////////////////////////////////////////////////////
  // fetch and decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ir <= '0;  // opcode 0 decodes as nop
    end else if (ir_ld) begin
      ir <= if_rdt;
    end
  end

  assign ctl    = dec(ir);
  assign if_adr = pc;
  assign ls_cap = ls_req && ls_ack && !ctl.ls.we;

  r5p_ctl r5p_ctl_inst (
    .clk    (clk),
    .rst    (rst),
    .if_ack (if_ack),
    .ls_ack (ls_ack),
    .ls     (ctl.ls),
    .if_req (if_req),
    .ls_req (ls_req),
    .pc_upd (pc_upd),
    .gpr_we (gpr_we),
    .ir_ld  (ir_ld)
  );

  r5p_pc r5p_pc_inst (
    .clk     (clk),
    .rst     (rst),
    .pc_upd  (pc_upd),
    .kind    (ctl.pc),
    .tkn     (tkn),
    .imm     (ctl.imm),
    .alu_sum (alu_sum),
    .pc      (pc),
    .pci     (pci)
  );

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////

  r5p_gpr r5p_gpr_inst (
    .clk   (clk),
    .rst   (rst),
    .ctl   (ctl.gpr),
    .we    (gpr_we),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  // operand muxes
  assign alu_rs1 = (ctl.a1 == A1_PC) ? XW'(pc) : gpr_rs1;  // pc for auipc and jal
  assign alu_rs2 = (ctl.a2 == A2_IMM) ? ctl.imm : gpr_rs2;

  r5p_alu r5p_alu_inst (
    .ao  (ctl.ao),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  r5p_br r5p_br_inst (
    .br  (ctl.br),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (tkn)
  );

  r5p_lsu r5p_lsu_inst (
    .clk    (clk),
    .rst    (rst),
    .ls     (ctl.ls),
    .cap    (ls_cap),
    .adr_t  (alu_sum),   // rs1 + imm
    .wdt_t  (gpr_rs2),
    .ls_rdt (ls_rdt),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .rdt    (lsu_rdt)
  );

  ////////////////////////////////////////////////////////////
  // write back
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ctl.wb)
      WB_ALU:  gpr_rd = alu_rd;
      WB_MEM:  gpr_rd = lsu_rdt;
      WB_PCI:  gpr_rd = XW'(pci);  // jal/jalr link
      WB_IMM:  gpr_rd = ctl.imm;   // lui, U immediate
      default: gpr_rd = '0;
    endcase
  end

endmodule

// ==== hw/r5p_ctl.sv ====
`timescale 1ns/1ns

module r5p_ctl (
  input  logic              clk,
  input  logic              rst,
  input  logic              if_ack,
  input  logic              ls_ack,
  input  r5p_pkg::ls_ctl_t  ls,
  output logic              if_req,
  output logic              ls_req,
  output logic              pc_upd,
  output logic              gpr_we,
  output logic              ir_ld
);

  import r5p_pkg::*;

  ctl_state_t state;
  ctl_state_t state_nxt;
  logic       run;  // low for the first cycle out of reset

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      run   <= 1'b0;
      state <= FETCH;
    end else begin
      run   <= 1'b1;
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;  // hold while waiting on an ack
    case (state)
      FETCH: if (if_req && if_ack) state_nxt = EXEC;
      EXEC:  state_nxt = ls.en ? MEM : FETCH;
      MEM:   if (ls_ack) state_nxt = ls.we ? FETCH : WB;
      WB:    state_nxt = FETCH;
      default: state_nxt = FETCH;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // strobes
  ////////////////////////////////////////////////////////////

  assign if_req = run && (state == FETCH);
  assign ls_req = (state == MEM);
  assign ir_ld  = if_req && if_ack;

  // instruction done: alu op in exec, store on ack, load after wb
  assign pc_upd = ((state == EXEC) && !ls.en)
               || ((state == MEM) && ls_ack && ls.we)
               || (state == WB);

  assign gpr_we = ((state == EXEC) && !ls.en) || (state == WB);  // gated by rd request in gpr

endmodule

// ==== hw/r5p_gpr.sv ====
`timescale 1ns/1ns

module r5p_gpr (
  input  logic                     clk,
  input  logic                     rst,
  input  r5p_pkg::gpr_ctl_t        ctl,
  input  logic                     we,
  input  logic [r5p_pkg::XW-1:0]   d_rd,
  output logic [r5p_pkg::XW-1:0]   d_rs1,
  output logic [r5p_pkg::XW-1:0]   d_rs2
);

  import r5p_pkg::*;

  logic [XW-1:0] x [1:2**GAW-1];  // x0 not stored

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 2**GAW; i++) begin
        x[i] <= '0;
      end
    end else if (we && ctl.we && (ctl.rd != '0)) begin
      x[ctl.rd] <= d_rd;
    end
  end

  // async read, x0 reads zero
  assign d_rs1 = (ctl.rs1 == '0) ? '0 : x[ctl.rs1];
  assign d_rs2 = (ctl.rs2 == '0) ? '0 : x[ctl.rs2];

endmodule

// ==== hw/r5p_lsu.sv ====
`timescale 1ns/1ns

module r5p_lsu (
  input  logic                         clk,
  input  logic                         rst,
  input  r5p_pkg::ls_ctl_t             ls,
  input  logic                         cap,     // load ack
  input  logic [r5p_pkg::XW-1:0]       adr_t,   // byte address from alu sum
  input  logic [r5p_pkg::XW-1:0]       wdt_t,   // rs2 store value
  input  logic [8*r5p_pkg::DSW-1:0]    ls_rdt,
  output logic                         ls_wen,
  output logic [r5p_pkg::DAW-1:0]      ls_adr,
  output logic [r5p_pkg::DSW-1:0]      ls_sel,
  output logic [8*r5p_pkg::DSW-1:0]    ls_wdt,
  output logic [r5p_pkg::XW-1:0]       rdt      // extended load data for wb
);

  import r5p_pkg::*;

  logic [DWW-1:0]   off;  // byte offset in word
  logic [8*DSW-1:0] tmp;  // read word shifted down
  logic [XW-1:0]    ext;

  assign off    = adr_t[DWW-1:0];
  assign ls_wen = ls.we;
  assign ls_adr = {adr_t[DAW-1:DWW], DWW'(0)};  // word aligned

  ////////////////////////////////////////////////////////////
  // store path
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ls.sz)
      SZ_B: begin
        ls_sel = DSW'(4'b0001) << off;
        ls_wdt = (wdt_t & 32'h0000_00ff) << {off, 3'b000};
      end
      SZ_H: begin
        ls_sel = DSW'(4'b0011) << off;
        ls_wdt = (wdt_t & 32'h0000_ffff) << {off, 3'b000};
      end
      default: begin  // word, offset always zero
        ls_sel = '1;
        ls_wdt = wdt_t;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // load path
  ////////////////////////////////////////////////////////////

  assign tmp = ls_rdt >> {off, 3'b000};  // addressed byte to lane 0

  always_comb begin
    case (ls.sz)
      SZ_B:    ext = ls.sg ? {{24{tmp[7]}}, tmp[7:0]} : {24'h0, tmp[7:0]};
      SZ_H:    ext = ls.sg ? {{16{tmp[15]}}, tmp[15:0]} : {16'h0, tmp[15:0]};
      default: ext = tmp;
    endcase
  end

  // held for the wb cycle
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rdt <= '0;
    end else if (cap) begin
      rdt <= ext;
    end
  end

endmodule

// ==== hw/r5p_pc.sv ====
`timescale 1ns/1ns

module r5p_pc (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pc_upd,
  input  r5p_pkg::pc_t              kind,
  input  logic                      tkn,
  input  logic [r5p_pkg::XW-1:0]    imm,
  input  logic [r5p_pkg::XW-1:0]    alu_sum,
  output logic [r5p_pkg::IAW-1:0]   pc,
  output logic [r5p_pkg::IAW-1:0]   pci
);

  import r5p_pkg::*;

  logic [IAW-1:0] pcb;  // branch target
  logic [IAW-1:0] pcn;  // next pc

  assign pci = pc + IAW'(4);
  assign pcb = pc + IAW'(imm);

  always_comb begin
    case (kind)
      PC_PCI:          pcn = pci;
      PC_BRN:          pcn = tkn ? pcb : pci;
      PC_JAL, PC_JALR: pcn = {alu_sum[IAW-1:1], 1'b0};  // lsb cleared as jalr demands
      default:         pcn = pci;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= PC0;
    end else if (pc_upd) begin
      pc <= pcn;
    end
  end

endmodule

// ==== r5p.f ====
common/r5p_pkg.sv
hw/r5p_ctl.sv
hw/r5p_pc.sv
hw/r5p_gpr.sv
hw/r5p_alu.sv
hw/r5p_br.sv
hw/r5p_lsu.sv
hw/r5p_core.sv
testbench/tb_r5p.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the r5p testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_r5p -f r5p.f -Mdir obj_dir

out=$(./obj_dir/Vtb_r5p)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== testbench/tb_r5p.sv ====
`timescale 1ns/1ns

module tb_r5p;

  localparam int          NT      = 32;             // table capacity
  localparam logic [31:0] RES_ADR = 32'h0000_0100;  // result word
  localparam logic [31:0] NOP     = 32'h0000_0013;  // addi x0,x0,0
  localparam logic [31:0] HALT    = 32'h0000_006f;  // jal x0,0

  typedef struct packed {
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] wdt;
  } store_t;

  logic        clk    = 1'b0;
  logic        rst    = 1'b1;
  logic        if_req;
  logic [31:0] if_adr;
  logic [31:0] if_rdt = '0;
  logic        if_ack = 1'b0;
  logic        ls_req;
  logic        ls_wen;
  logic [31:0] ls_adr;
  logic [3:0]  ls_sel;
  logic [31:0] ls_wdt;
  logic [31:0] ls_rdt = '0;
  logic        ls_ack = 1'b0;

  string       t_name [NT];
  logic [31:0] t_prog [NT][8];
  store_t      t_exp  [NT];
  int          nt     = 0;
  int          cur    = 0;    // row in the memories
  logic        rnd    = 1'b0; // random wait states
  logic [31:0] seed   = 32'h6193_5ed0;
  logic [31:0] pmem [64];
  logic [31:0] dmem [64];
  int          if_wait;
  int          ls_wait;
  logic        st_seen = 1'b0;
  store_t      st      = '0;  // first store of the row
  int          errors  = 0;
  int          fails   = 0;

  always #10 clk = ~clk;

  r5p_core r5p_core_inst (
    .clk    (clk),
    .rst    (rst),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack)
  );

  ////////////////////////////////////////////////////////////
  // instruction encoders with args in assembly order
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rtype(input int f7, input int f3, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] itype(input int opc, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] stype(input int f3, input int rs2, input int rs1,
                                        input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype(input int f3, input int rs1, input int rs2,
                                        input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] utype(input int opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] jtype(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return itype('h13, 0, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] store_word(input int rs2);
    return stype(2, rs2, 0, 'h100);  // sw rs2,0x100(x0)
  endfunction

  ////////////////////////////////////////////////////////////
  // bus models
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int draw_wait();
    seed = lcg(seed);
    if (rnd) return int'(seed[31:16] % 16'd3);  // 0..2 wait cycles
    return 0;
  endfunction

  always @(negedge clk) begin
    if (rst) begin
      if_ack  <= 1'b0;
      ls_ack  <= 1'b0;
      st_seen <= 1'b0;
      if_wait = 0;
      ls_wait = 0;
      for (int i = 0; i < 64; i++) begin
        if (i < 8) pmem[i] = t_prog[cur][i];
        else pmem[i] = addi(0, 0, i);  // nop tagged with its own index
        dmem[i] = 32'h80f1_7e92 ^ (i * 32'h0404_0404);
      end
    end else begin
      if_ack <= 1'b0;
      ls_ack <= 1'b0;
      if (if_req && if_wait == 0) begin
        if_ack  <= 1'b1;
        if_rdt  <= pmem[if_adr[7:2]];
        if_wait = draw_wait();
      end else if (if_req) begin
        if_wait = if_wait - 1;
      end
      if (ls_req && ls_wait == 0) begin
        ls_ack <= 1'b1;
        ls_rdt <= dmem[ls_adr[7:2]];  // 0x100 aliases word 0
        if (ls_wen) begin
          for (int b = 0; b < 4; b++) begin
            if (ls_sel[b]) dmem[ls_adr[7:2]][8*b +: 8] = ls_wdt[8*b +: 8];
          end
          if (!st_seen) begin
            st_seen <= 1'b1;
            st      <= '{adr: ls_adr, sel: ls_sel, wdt: ls_wdt};
          end
        end
        ls_wait = draw_wait();
      end else if (ls_req) begin
        ls_wait = ls_wait - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input logic [3:0] sel, input logic [31:0] wdt,
                         input logic [31:0] p0, p1, p2, p3, p4, p5, p6, p7);
    t_name[nt] = name;
    t_exp[nt]  = '{adr: RES_ADR, sel: sel, wdt: wdt};
    t_prog[nt] = '{p0, p1, p2, p3, p4, p5, p6, p7};
    nt++;
  endtask

  // with x1=-2 and x2=3 the taken branch skips +1 and the untaken one runs +2
  task automatic add_br(input string name, input int f3, input int ta, input int tb,
                        input int na, input int nb);
    add_row(name, 4'hf, 2, addi(1, 0, -2), addi(2, 0, 3), btype(f3, ta, tb, 8),
            addi(3, 3, 1), btype(f3, na, nb, 8), addi(3, 3, 2), store_word(3), HALT);
  endtask

  // x1 = 0x12345678 stored as byte or half at 0x100+off
  task automatic add_st(input string name, input int f3, input int off,
                        input logic [3:0] sel, input logic [31:0] wdt);
    add_row(name, sel, wdt, utype('h37, 1, 'h12345), addi(1, 1, 'h678),
            stype(f3, 1, 0, 'h100 + off), HALT, NOP, NOP, NOP, NOP);
  endtask

  // data word 0 holds 0x80f1_7e92
  task automatic add_ld(input string name, input int f3, input int off,
                        input logic [31:0] val);
    add_row(name, 4'hf, val, itype('h03, f3, 1, 0, off), store_word(1), HALT,
            NOP, NOP, NOP, NOP, NOP);
  endtask

  function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic run_row(input int n, input logic mode);
    int errs0;
    errs0 = errors;
    @(negedge clk);
    cur <= n;
    rnd <= mode;
    rst <= 1'b1;
    repeat (5) @(negedge clk);  // memories reload while in reset
    rst <= 1'b0;
    for (int c = 0; c < 2000; c++) begin
      @(negedge clk);
      if (st_seen) break;
    end
    if (!st_seen) begin
      $display("test %s: the core made no store within 2000 cycles", t_name[n]);
      errors++;
    end else begin
      compare({t_name[n], " adr"}, t_exp[n].adr, st.adr);
      compare({t_name[n], " sel"}, 32'(t_exp[n].sel), 32'(st.sel));
      compare({t_name[n], " wdt"}, t_exp[n].wdt, st.wdt & lane_mask(st.sel));
    end
    if (errors != errs0) fails++;
    $display("%s %s: %s", mode ? "random " : "no wait", t_name[n],
             (errors == errs0) ? "ok" : "failed");
  endtask

  initial begin
    // alu rows
    add_row("add_sub", 4'hf, 32'hffff_ff9c, addi(1, 0, 100), addi(2, 0, -30),
            rtype(0, 0, 3, 1, 2), rtype('h20, 0, 4, 2, 3), store_word(4), HALT, NOP, NOP);
    add_row("logic", 4'hf, 32'h0000_0529, addi(1, 0, 'h6b5), addi(2, 0, 'h39c),
            rtype(0, 7, 3, 1, 2), rtype(0, 6, 4, 3, 1), rtype(0, 4, 5, 4, 2),
            store_word(5), HALT, NOP);
    add_row("slt", 4'hf, 32'h0000_0002, addi(1, 0, -1), addi(2, 0, 1),
            rtype(0, 2, 3, 1, 2), rtype(0, 3, 4, 1, 2), itype('h13, 1, 3, 3, 1),
            rtype(0, 6, 5, 3, 4), store_word(5), HALT);
    add_row("shift", 4'hf, 32'h0fff_fff0, addi(1, 0, -256), addi(2, 0, 4),
            rtype(0, 1, 3, 1, 2), rtype('h20, 5, 4, 3, 2), rtype(0, 5, 5, 4, 2),
            store_word(5), HALT, NOP);
    add_br("beq", 0, 1, 1, 1, 2);
    add_br("bne", 1, 1, 2, 1, 1);
    add_br("blt", 4, 1, 2, 2, 1);
    add_br("bge", 5, 2, 1, 1, 2);
    add_br("bltu", 6, 2, 1, 1, 2);
    add_br("bgeu", 7, 1, 2, 2, 1);
    add_row("jal", 4'hf, 32'h0000_000c, NOP, NOP, jtype(1, 8), addi(1, 0, 0),
            store_word(1), HALT, NOP, NOP);  // link = 8 + 4
    add_st("sb0", 0, 0, 4'b0001, 32'h0000_0078);
    add_st("sb1", 0, 1, 4'b0010, 32'h0000_7800);
    add_st("sb2", 0, 2, 4'b0100, 32'h0078_0000);
    add_st("sb3", 0, 3, 4'b1000, 32'h7800_0000);
    add_st("sh0", 1, 0, 4'b0011, 32'h0000_5678);
    add_st("sh2", 1, 2, 4'b1100, 32'h5678_0000);
    add_ld("lb0", 0, 0, 32'hffff_ff92);
    add_ld("lb1", 0, 1, 32'h0000_007e);
    add_ld("lbu2", 4, 2, 32'h0000_00f1);
    add_ld("lh2", 1, 2, 32'hffff_80f1);
    add_ld("lhu0", 5, 0, 32'h0000_7e92);
    add_row("lui", 4'hf, 32'hfedc_b000, utype('h37, 1, 'hfedcb), store_word(1), HALT,
            NOP, NOP, NOP, NOP, NOP);
    add_row("auipc", 4'hf, 32'h0000_1008, NOP, NOP, utype('h17, 1, 1), store_word(1),
            HALT, NOP, NOP, NOP);  // pc 8 + 0x1000
    add_row("x0", 4'hf, 32'h0000_0007, utype('h37, 0, 'h12345), addi(0, 0, 55),
            addi(1, 0, 7), store_word(1), HALT, NOP, NOP, NOP);
    for (int m = 0; m < 2; m++) begin
      for (int n = 0; n < nt; n++) run_row(n, m == 1);
    end
    $display("%0d tests run, %0d passed, %0d failed", 2 * nt, 2 * nt - fails, fails);
    if (fails == 0 && errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
